// ==== Bender.yml ====
package:
  name: load_store_datapath

sources:
  - target: any(rtl, test)
    include_dirs:
      - verilog
    files:
      - verilog/cpuDataPkg.sv
      - verilog/cpuCtrlPkg.sv
      - verilog/registerFile.sv
      - verilog/busMux.sv
      - verilog/addrAlu.sv
      - verilog/memUnit.sv
      - verilog/controlSequencer.sv
      - verilog/loadStoreDatapath.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/clockGen.sv
      - test/loadStoreTb.sv

// ==== build.f ====
+incdir+verilog
verilog/cpuDataPkg.sv
verilog/cpuCtrlPkg.sv
verilog/registerFile.sv
verilog/busMux.sv
verilog/addrAlu.sv
verilog/memUnit.sv
verilog/controlSequencer.sv
verilog/loadStoreDatapath.sv
test/clockGen.sv
test/loadStoreTb.sv

// ==== test/clockGen.sv ====
`timescale 1ns/100ps
`default_nettype none

module clockGen (
	output logic clk,
	output logic rstN
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;   // 10 ns period
	end

	initial begin
		rstN = 1'b0;
		repeat (16) @(posedge clk);
		rstN <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== test/loadStoreTb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpu_consts.svh"

module loadStoreTb;
	import cpuDataPkg::*;

	localparam int ACK_LATENCY = 9;
	localparam int ACK_TIMEOUT = 40;
	localparam int CHECK_TIMEOUT = 100;
	localparam int IDLE_LIMIT = 2000;
	localparam logic [26:0] FIXED_WATCH = {9'h100, 9'h155, 9'h1ff};  // data words always peeked

	logic     clk, rstN;
	logic     runReq, runAck, loadEn;
	memAddr_t loadAddr, peekAddr;
	word_t    loadData, peekData, dbgData, pc;
	regIdx_t  dbgSel;

	// software model of the machine state
	word_t    modelRegs [`REG_COUNT];
	word_t    modelMem [`MEM_DEPTH];
	word_t    modelPc;
	memAddr_t lastEa;

	word_t    rngState = 32'd72031;
	int       errorCount = 0;
	int       testCount = 0;
	int       failCount = 0;
	int       checkSeq = 0;
	int       doneSeq = 0;
	bit       hung = 1'b0;

	clockGen clockGen_inst (.clk(clk), .rstN(rstN));

	loadStoreDatapath loadStoreDatapath_inst (
		.clk(clk), .rstN(rstN), .runReq(runReq), .runAck(runAck),
		.loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
		.peekAddr(peekAddr), .peekData(peekData), .dbgSel(dbgSel), .dbgData(dbgData), .pc(pc)
	);

	function automatic word_t nextRandom();
		word_t x;
		x = rngState;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rngState = x;
		return x;
	endfunction

	function automatic word_t makeInstr(input logic [4:0] op, input regIdx_t ra,
			input regIdx_t rb, input logic [18:0] c);
		return {op, ra, rb, c};
	endfunction

	function automatic word_t fillWord(input memAddr_t a);
		return {a, 7'h35, ~a, 7'h4b};
	endfunction

	// constant that puts base plus C on target in the low address bits
	function automatic logic [18:0] constFor(input regIdx_t rb, input memAddr_t target);
		word_t       base;
		word_t       r;
		logic [18:0] c;
		base = (rb == 0) ? '0 : modelRegs[rb];
		r = nextRandom();
		c = r[18:0];                     // random upper bits so C is often negative
		c[8:0] = target - base[8:0];
		return c;
	endfunction

	// reference model, one instruction
	function automatic void modelExecute(input word_t instr);
		regIdx_t            ra;
		regIdx_t            rb;
		logic signed [18:0] c;
		word_t              ea;
		ra = instr[26:23];
		rb = instr[22:19];
		c = instr[18:0];
		ea = int'(c);                   // two's complement constant
		if (rb != 0)
			ea = ea + modelRegs[rb];    // Rb of zero is a zero base
		modelPc = modelPc + 1;
		case (instr[31:27])
			5'd0: modelRegs[ra] = modelMem[ea[`ADDR_WIDTH-1:0]];
			5'd1: modelRegs[ra] = ea;
			5'd2: modelMem[ea[`ADDR_WIDTH-1:0]] = modelRegs[ra];
			default: ;
		endcase
		lastEa = ea[`ADDR_WIDTH-1:0];
	endfunction

	task automatic loadWord(input memAddr_t a, input word_t d);
		@(posedge clk);
		loadEn   <= 1'b1;
		loadAddr <= a;
		loadData <= d;
		modelMem[a] = d;
	endtask

	task automatic releaseLoad();
		@(posedge clk);
		loadEn <= 1'b0;
	endtask

	// negedges until runAck reaches level
	task automatic waitAck(input logic level, output int waited);
		waited = 0;
		@(negedge clk);
		while (runAck !== level && waited < ACK_TIMEOUT) begin
			waited++;
			@(negedge clk);
		end
		if (runAck !== level) begin
			$display("runAck did not go to %0d within %0d cycles", level, ACK_TIMEOUT);
			hung = 1'b1;
		end
	endtask

	task automatic requestCheck();
		int n;
		if (hung)
			return;
		@(negedge clk);
		checkSeq++;
		n = 0;
		while (doneSeq != checkSeq && n < CHECK_TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (doneSeq != checkSeq) begin
			$display("compare process did not finish a check within %0d cycles", CHECK_TIMEOUT);
			hung = 1'b1;
		end
	endtask

	// four-phase run of one instruction with runReq held extraHold cycles past the check
	task automatic runInstr(input word_t instr, input int extraHold);
		int waited;
		if (hung)
			return;
		loadWord(modelPc[`ADDR_WIDTH-1:0], instr);
		releaseLoad();
		@(posedge clk);
		runReq <= 1'b1;
		@(posedge clk);             // edge that samples runReq
		waitAck(1'b1, waited);
		if (hung)
			return;
		assert (waited == ACK_LATENCY) else begin
			$display("Error: runAck latency = 0x%0h cycles, expected 0x%0h", waited, ACK_LATENCY);
			errorCount++;
		end
		modelExecute(instr);
		requestCheck();
		for (int i = 0; i < extraHold; i++) begin
			@(negedge clk);
			assert (runAck === 1'b1) else begin
				$display("Error: runAck = 0x%0h while runReq held, expected 0x1", runAck);
				errorCount++;
			end
		end
		@(posedge clk);
		runReq <= 1'b0;
		waitAck(1'b0, waited);
	endtask

	task automatic compareAll();
		memAddr_t a;
		for (int i = 0; i < `REG_COUNT; i++) begin
			dbgSel <= regIdx_t'(i);
			@(negedge clk);
			assert (dbgData === modelRegs[i]) else begin
				$display("Error: dbgData R%0d = 0x%08h, expected 0x%08h", i, dbgData, modelRegs[i]);
				errorCount++;
			end
			@(posedge clk);
		end
		// last effective address, its neighbours, then the fixed words
		for (int i = 0; i < 6; i++) begin
			a = (i < 3) ? lastEa + memAddr_t'(i) - memAddr_t'(1) : FIXED_WATCH[9*(i-3) +: 9];
			peekAddr <= a;
			@(negedge clk);
			assert (peekData === modelMem[a]) else begin
				$display("Error: peekData[0x%03h] = 0x%08h, expected 0x%08h", a, peekData, modelMem[a]);
				errorCount++;
			end
			@(posedge clk);
		end
		@(negedge clk);
		assert (pc === modelPc) else begin
			$display("Error: pc = 0x%08h, expected 0x%08h", pc, modelPc);
			errorCount++;
		end
	endtask

	task automatic reportTest(input string name, input int errorsBefore);
		testCount++;
		if (errorCount == errorsBefore && !hung) begin
			$display("test %0d %s: ok", testCount, name);
		end else begin
			failCount++;
			$display("test %0d %s: failed", testCount, name);
		end
	endtask

	initial begin : compareProc
		int idle;
		dbgSel   = '0;
		peekAddr = '0;
		while (!hung) begin
			idle = 0;
			while (checkSeq == doneSeq && idle < IDLE_LIMIT) begin
				@(posedge clk);
				idle++;
			end
			if (checkSeq == doneSeq) begin
				$display("compare process got no request for %0d cycles", IDLE_LIMIT);
				hung = 1'b1;
			end else begin
				compareAll();
				@(posedge clk);
				doneSeq = checkSeq;
			end
		end
	end

	initial begin : stimulus
		int         n;
		int         errs;
		word_t      r;
		regIdx_t    ra;
		regIdx_t    rb;
		memAddr_t   target;
		logic [4:0] op;
		runReq   = 1'b0;
		loadEn   = 1'b0;
		loadAddr = '0;
		loadData = '0;
		modelPc  = '0;
		lastEa   = 9'h100;
		for (int i = 0; i < `REG_COUNT; i++)
			modelRegs[i] = '0;
		n = 0;
		while (rstN !== 1'b1 && n < 100) begin
			@(posedge clk);
			n++;
		end
		if (rstN !== 1'b1) begin
			$display("reset was never released");
			hung = 1'b1;
		end

		errs = errorCount;
		@(negedge clk);
		assert (runAck === 1'b0) else begin
			$display("Error: runAck = 0x%0h after reset, expected 0x0", runAck);
			errorCount++;
		end
		for (int a = 0; a < `MEM_DEPTH; a++)
			loadWord(memAddr_t'(a), fillWord(memAddr_t'(a)));
		releaseLoad();
		requestCheck();
		reportTest("reset state", errs);

		errs = errorCount;
		r = nextRandom();
		runInstr(makeInstr(5'd1, 4'd0, 4'd0, r[18:0]), 2);
		runInstr(makeInstr(5'd1, 4'd5, 4'd0, 19'h7fffd), 2);   // -3 on a zero base while R0 is set
		for (int k = 1; k < `REG_COUNT; k++) begin
			r = nextRandom();
			runInstr(makeInstr(5'd1, regIdx_t'(k), regIdx_t'(k - 1), r[18:0]), 2);
		end
		reportTest("ldi", errs);

		errs = errorCount;
		for (int k = 0; k < 6; k++) begin
			r = nextRandom();
			target = {1'b1, r[7:0]};   // upper half of memory
			loadWord(target, nextRandom());
			releaseLoad();
			ra = r[11:8];
			rb = r[15:12];
			runInstr(makeInstr(5'd0, ra, rb, constFor(rb, target)), 2);
		end
		reportTest("ld", errs);

		errs = errorCount;
		for (int k = 0; k < 6; k++) begin
			r = nextRandom();
			target = {1'b1, r[7:0]};
			ra = r[11:8];
			rb = r[15:12];
			runInstr(makeInstr(5'd2, ra, rb, constFor(rb, target)), 2);
		end
		runInstr(makeInstr(5'd0, ra + 4'd1, 4'd0, {10'd0, target}), 2);   // read back
		reportTest("st", errs);

		errs = errorCount;
		for (int k = 0; k < 6; k++) begin
			r = nextRandom();
			op = 5'd3 + r[31:27] % 5'd29;
			runInstr({op, r[26:0]}, 2);
		end
		reportTest("undefined opcodes", errs);

		errs = errorCount;
		r = nextRandom();
		runInstr(makeInstr(5'd1, 4'd7, 4'd3, r[18:0]), 20);
		for (int k = 0; k < 6; k++) begin
			@(negedge clk);
			assert (runAck === 1'b0 && pc === modelPc) else begin
				$display("Error: runAck = 0x%0h pc = 0x%08h after release, expected 0x0 0x%08h",
					runAck, pc, modelPc);
				errorCount++;
			end
		end
		reportTest("handshake", errs);

		$display("%0d tests, %0d failed, %0d errors", testCount, failCount, errorCount);
		if (hung || errorCount != 0 || failCount != 0)
			$display("FAIL: see errors above");
		else
			$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/addrAlu.sv ====
`timescale 1ns/100ps
`default_nettype none

module addrAlu (
	input  logic              clk,
	input  logic              rstN,
	input  cpuDataPkg::word_t bus,
	input  logic              yIn,
	input  logic              zIn,
	input  logic              incPc,
	output cpuDataPkg::word_t zLo
);
	import cpuDataPkg::*;

	word_t y;      // first operand, latched from the bus
	word_t sum;

	// increment for the fetch, add for base plus constant
	assign sum = incPc ? bus + word_t'(1) : y + bus;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			y <= '0;
		else if (yIn)
			y <= bus;
	end

	// low half of Z only
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			zLo <= '0;
		else if (zIn)
			zLo <= sum;
	end

endmodule

`default_nettype wire

// ==== verilog/busMux.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpu_consts.svh"

module busMux (
	input  cpuCtrlPkg::busSrc_t busSrc,
	input  cpuDataPkg::word_t   regOut,
	input  cpuDataPkg::word_t   pc,
	input  cpuDataPkg::word_t   zLo,
	input  cpuDataPkg::word_t   mdr,
	input  cpuDataPkg::word_t   ir,
	output cpuDataPkg::word_t   bus
);
	import cpuDataPkg::*;
	import cpuCtrlPkg::*;

	word_t constExt;

	// C field sign-extended to a full word
	assign constExt = {{(`WORD_WIDTH - `CONST_WIDTH){ir[`CONST_WIDTH-1]}},
		ir[`CONST_WIDTH-1:0]};

	// the only driver of the shared bus
	always_comb begin
		case (busSrc)
			srcReg:   bus = regOut;
			srcPc:    bus = pc;
			srcZlo:   bus = zLo;
			srcMdr:   bus = mdr;
			srcConst: bus = constExt;
			default:  bus = '0;   // srcNone
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/controlSequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module controlSequencer (
	input  logic                clk,
	input  logic                rstN,
	input  logic                runReq,
	output logic                runAck,
	input  cpuDataPkg::word_t   mdr,
	output cpuDataPkg::word_t   ir,
	output cpuCtrlPkg::busSrc_t busSrc,
	output logic                gra,
	output logic                grb,
	output logic                grc,
	output logic                rIn,
	output logic                baOut,
	output logic                pcIn,
	output logic                irIn,
	output logic                yIn,
	output logic                zIn,
	output logic                incPc,
	output logic                marIn,
	output logic                mdrIn,
	output logic                mdRead,
	output logic                memWrite
);
	import cpuCtrlPkg::*;

	step_t   state;
	step_t   nextState;
	opcode_t opcode;
	logic    execOp;    // ld, ldi or st

	assign opcode = opcode_t'(ir[31:27]);
	assign execOp = (opcode == opLd) || (opcode == opLdi) || (opcode == opSt);

	always_comb begin
		nextState = state;
		case (state)
			stIdle:  if (runReq) nextState = stT0;
			stT0:    nextState = stT1;
			stT1:    nextState = stT2;
			stT2:    nextState = stT3;
			stT3:    nextState = stT4;
			stT4:    nextState = stT5;
			stT5:    nextState = stT6;
			stT6:    nextState = stT7;
			stT7:    nextState = stDone;
			stDone:  if (runAck && !runReq) nextState = stIdle;
			default: nextState = stIdle;
		endcase
	end

	// runAck rises one cycle into stDone and falls with runReq
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state  <= stIdle;
			runAck <= 1'b0;
		end else begin
			state <= nextState;
			if (state == stDone) begin
				if (!runAck)
					runAck <= 1'b1;
				else if (!runReq)
					runAck <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			ir <= '0;
		else if (irIn)
			ir <= mdr;     // bus carries MDR in T2
	end

	// per-step strobes, Rc is never selected by this instruction set
	always_comb begin
		{gra, grb, grc, rIn, baOut, pcIn, irIn} = '0;
		{yIn, zIn, incPc, marIn, mdrIn, mdRead, memWrite} = '0;
		busSrc = srcNone;
		case (state)
			stT0: begin
				busSrc = srcPc;
				marIn  = 1'b1;
				zIn    = 1'b1;
				incPc  = 1'b1;
			end
			stT1: begin
				busSrc = srcZlo;
				pcIn   = 1'b1;
				mdrIn  = 1'b1;
				mdRead = 1'b1;
			end
			stT2: begin
				busSrc = srcMdr;
				irIn   = 1'b1;
			end
			stT3: if (execOp) begin
				busSrc = srcReg;   // base Rb, zero when Rb is 0
				grb    = 1'b1;
				baOut  = 1'b1;
				yIn    = 1'b1;
			end
			stT4: if (execOp) begin
				busSrc = srcConst;
				zIn    = 1'b1;
			end
			stT5: if (execOp) begin
				busSrc = srcZlo;
				if (opcode == opLdi) begin
					gra = 1'b1;
					rIn = 1'b1;
				end else begin
					marIn = 1'b1;
				end
			end
			stT6: case (opcode)
				opLd: begin
					mdrIn  = 1'b1;
					mdRead = 1'b1;
				end
				opSt: begin
					busSrc = srcReg;
					gra    = 1'b1;
					mdrIn  = 1'b1;
				end
				default: ;
			endcase
			stT7: case (opcode)
				opLd: begin
					busSrc = srcMdr;
					gra    = 1'b1;
					rIn    = 1'b1;
				end
				opSt: memWrite = 1'b1;
				default: ;
			endcase
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/cpuCtrlPkg.sv ====
`default_nettype none

package cpuCtrlPkg;

	// only the load family is executed, everything else is a no-op
	typedef enum logic [4:0] {
		opLd  = 5'b00000,
		opLdi = 5'b00001,
		opSt  = 5'b00010
	} opcode_t;

	typedef enum logic [2:0] {
		srcNone,   // bus reads as zero
		srcReg,
		srcPc,
		srcZlo,
		srcMdr,
		srcConst   // sign-extended C field
	} busSrc_t;

	// one step per clock
	typedef enum logic [3:0] {
		stIdle,
		stT0, stT1, stT2, stT3, stT4, stT5, stT6, stT7,
		stDone
	} step_t;

endpackage

`default_nettype wire

// ==== verilog/cpuDataPkg.sv ====
`default_nettype none

`include "cpu_consts.svh"

package cpuDataPkg;

	// bus, register and memory word
	typedef logic [`WORD_WIDTH-1:0] word_t;

	// general register index, as held in the Ra/Rb/Rc fields
	typedef logic [$clog2(`REG_COUNT)-1:0] regIdx_t;

	typedef logic [`ADDR_WIDTH-1:0] memAddr_t;  // word address into memory

endpackage

`default_nettype wire

// ==== verilog/cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// datapath word and register file size
`define WORD_WIDTH 32
`define REG_COUNT 16

// word memory, low address bits only
`define ADDR_WIDTH 9
`define MEM_DEPTH 512

// constant field C of the instruction, bits 18 to 0
`define CONST_WIDTH 19

`endif

// ==== verilog/loadStoreDatapath.sv ====
`timescale 1ns/100ps
`default_nettype none

module loadStoreDatapath (
	input  logic                 clk,
	input  logic                 rstN,
	input  logic                 runReq,
	output logic                 runAck,
	input  logic                 loadEn,
	input  cpuDataPkg::memAddr_t loadAddr,
	input  cpuDataPkg::word_t    loadData,
	input  cpuDataPkg::memAddr_t peekAddr,
	output cpuDataPkg::word_t    peekData,
	input  cpuDataPkg::regIdx_t  dbgSel,
	output cpuDataPkg::word_t    dbgData,
	output cpuDataPkg::word_t    pc
);
	import cpuDataPkg::*;
	import cpuCtrlPkg::*;

	word_t   bus;
	word_t   ir;
	word_t   regOut;
	word_t   zLo;
	word_t   mdr;
	busSrc_t busSrc;
	logic    gra, grb, grc, rIn, baOut, pcIn;
	logic    yIn, zIn, incPc, marIn, mdrIn, mdRead, memWrite;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			pc <= '0;
		else if (pcIn)
			pc <= bus;    // incremented PC comes back through Z
	end

	controlSequencer controlSequencer_inst (
		.clk(clk), .rstN(rstN), .runReq(runReq), .runAck(runAck),
		.mdr(mdr), .ir(ir), .busSrc(busSrc),
		.gra(gra), .grb(grb), .grc(grc), .rIn(rIn), .baOut(baOut),
		.pcIn(pcIn), .irIn(), .yIn(yIn), .zIn(zIn), .incPc(incPc),   // IR lives in the sequencer
		.marIn(marIn), .mdrIn(mdrIn), .mdRead(mdRead), .memWrite(memWrite)
	);

	busMux busMux_inst (
		.busSrc(busSrc), .regOut(regOut), .pc(pc), .zLo(zLo),
		.mdr(mdr), .ir(ir), .bus(bus)
	);

	registerFile registerFile_inst (
		.clk(clk), .rstN(rstN), .ir(ir),
		.gra(gra), .grb(grb), .grc(grc), .baOut(baOut), .rIn(rIn),
		.bus(bus), .regOut(regOut), .dbgSel(dbgSel), .dbgData(dbgData)
	);

	addrAlu addrAlu_inst (
		.clk(clk), .rstN(rstN), .bus(bus),
		.yIn(yIn), .zIn(zIn), .incPc(incPc), .zLo(zLo)
	);

	memUnit memUnit_inst (
		.clk(clk), .rstN(rstN), .bus(bus),
		.marIn(marIn), .mdrIn(mdrIn), .mdRead(mdRead), .memWrite(memWrite),
		.mdr(mdr), .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
		.peekAddr(peekAddr), .peekData(peekData)
	);

endmodule

`default_nettype wire

// ==== verilog/memUnit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpu_consts.svh"

module memUnit (
	input  logic                 clk,
	input  logic                 rstN,
	input  cpuDataPkg::word_t    bus,
	input  logic                 marIn,
	input  logic                 mdrIn,
	input  logic                 mdRead,
	input  logic                 memWrite,
	output cpuDataPkg::word_t    mdr,
	input  logic                 loadEn,
	input  cpuDataPkg::memAddr_t loadAddr,
	input  cpuDataPkg::word_t    loadData,
	input  cpuDataPkg::memAddr_t peekAddr,
	output cpuDataPkg::word_t    peekData
);
	import cpuDataPkg::*;

	word_t    mem [`MEM_DEPTH];
	memAddr_t mar;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			mar <= '0;
		else if (marIn)
			mar <= bus[`ADDR_WIDTH-1:0];   // upper address bits ignored
	end

	// MDR from memory on a read, else straight from the bus
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			mdr <= '0;
		else if (mdrIn)
			mdr <= mdRead ? mem[mar] : bus;
	end

	// preload port wins over a store
	always_ff @(posedge clk) begin
		if (loadEn)
			mem[loadAddr] <= loadData;
		else if (memWrite)
			mem[mar] <= mdr;
	end

	assign peekData = mem[peekAddr];

endmodule

`default_nettype wire

// ==== verilog/registerFile.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpu_consts.svh"

module registerFile (
	input  logic                  clk,
	input  logic                  rstN,
	input  cpuDataPkg::word_t     ir,
	input  logic                  gra,
	input  logic                  grb,
	input  logic                  grc,
	input  logic                  baOut,
	input  logic                  rIn,
	input  cpuDataPkg::word_t     bus,
	output cpuDataPkg::word_t     regOut,
	input  cpuDataPkg::regIdx_t   dbgSel,
	output cpuDataPkg::word_t     dbgData
);
	import cpuDataPkg::*;

	word_t   regs [`REG_COUNT];
	regIdx_t sel;

	// register index from the IR field named by the strobe
	always_comb begin
		sel = '0;
		if (gra)
			sel = ir[26:23];      // Ra
		else if (grb)
			sel = ir[22:19];      // Rb
		else if (grc)
			sel = ir[18:15];      // Rc
	end

	// Rb of zero means a zero base, not R0
	assign regOut = (baOut && sel == '0) ? '0 : regs[sel];

	assign dbgData = regs[dbgSel];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end else if (rIn) begin
			regs[sel] <= bus;
		end
	end

endmodule

`default_nettype wire
